// ==== logic/motorCtrlPkg.sv ====
/*
 * motor control package
 * address map, widths, fifo depth and the adc sample layout
 */
`default_nettype none

package motorCtrlPkg;

    // ========================================
    // widths and sizes
    // ========================================
    localparam int motorCount  = 4;
    localparam int wordWidth   = 32;
    localparam int addrWidth   = 5;
    // {volt strobe, amp strobe, volt sample, amp sample}
    localparam int sensorWidth = 34;
    localparam int sampleWidth = 16;
    localparam int adcWidth    = 12;
    localparam int fifoDepth   = 8;

    // ========================================
    // address map
    // ========================================
    localparam int addrPwmDuty    = 0;
    localparam int addrDriverDir  = 1;
    localparam int addrFbDir      = 2;
    localparam int addrControl    = 3;
    localparam int addrFifoStatus = 4;
    // motor A starts here, one block of five words per motor
    localparam int addrMotorBase  = 7;
    localparam int motorStride    = 5;

    // offsets inside a motor block, offset 4 reserved
    localparam int offEncoder = 0;
    localparam int offSpeed   = 1;
    localparam int offVolt    = 2;
    localparam int offAmp     = 3;

    // control bit 31 holds every fifo empty
    localparam int clearAllBit = 31;
    localparam logic [wordWidth-1:0] reservedPattern = 32'hDEADBEEF;

    // adc word as stored raw, or split into its fields
    typedef union packed {
        logic [sampleWidth-1:0] raw;
        struct packed {
            logic                zero;
            logic [2:0]          channel;
            logic [adcWidth-1:0] adc;
        } field;
    } adcSample_u;

endpackage

`default_nettype wire

// ==== logic/sensorFifo.sv ====
/*
 * sensor fifo
 * single-clock show-ahead buffer, oldest entry always on head
 */
`timescale 1ns/1ps
`default_nettype none

module sensorFifo #(
    parameter int dataWidth = motorCtrlPkg::wordWidth,
    parameter int depth     = motorCtrlPkg::fifoDepth
) (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  clear,
    input  wire                  push,
    input  wire  [dataWidth-1:0] pushData,
    input  wire                  pop,
    output logic [dataWidth-1:0] head,
    output logic                 notEmpty
);

    // pointer needs at least one bit, even for a single entry
    localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntWidth = $clog2(depth + 1);
    localparam logic [ptrWidth-1:0] lastPtr   = ptrWidth'(depth - 1);
    localparam logic [cntWidth-1:0] fullCount = cntWidth'(depth);

    logic [dataWidth-1:0] mem [depth];
    logic [ptrWidth-1:0]  rdPtr;
    logic [ptrWidth-1:0]  wrPtr;
    logic [cntWidth-1:0]  count;
    logic                 doPush;
    logic                 doPop;

    // wrap at depth, works for any depth
    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        return (ptr == lastPtr) ? '0 : ptr + 1'b1;
    endfunction

    // pop of an empty buffer is ignored
    assign doPop  = pop && notEmpty && !clear;
    // full buffer still takes a push when the same cycle pops
    assign doPush = push && !clear && ((count != fullCount) || doPop);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (clear) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    // show-ahead
    assign head     = mem[rdPtr];
    assign notEmpty = (count != '0);

    countInRange: assert property (@(posedge clk) disable iff (!reset_n) count <= fullCount)
        else $error("sensorFifo occupancy above depth");

endmodule

`default_nettype wire

// ==== logic/feedbackBank.sv ====
/*
 * motor feedback bank
 * speed, voltage and current fifos of all four motors
 * plus the fifo status word
 */
`timescale 1ns/1ps
`default_nettype none

module feedbackBank (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire                                   clearAll,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    speedIn [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::sensorWidth-1:0]  sensorIn [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::motorCount-1:0]   popSpeed,
    input  wire  [motorCtrlPkg::motorCount-1:0]   popVolt,
    input  wire  [motorCtrlPkg::motorCount-1:0]   popAmp,
    output logic [motorCtrlPkg::wordWidth-1:0]    speedHead [motorCtrlPkg::motorCount],
    output logic [motorCtrlPkg::sampleWidth-1:0]  voltHead [motorCtrlPkg::motorCount],
    output logic [motorCtrlPkg::sampleWidth-1:0]  ampHead [motorCtrlPkg::motorCount],
    output logic [motorCtrlPkg::wordWidth-1:0]    fifoStatus
);

    logic [motorCtrlPkg::motorCount-1:0] speedNotEmpty;
    logic [motorCtrlPkg::motorCount-1:0] voltNotEmpty;
    logic [motorCtrlPkg::motorCount-1:0] ampNotEmpty;

    // ========================================
    // per motor fifos
    // ========================================
    for (genvar m = 0; m < motorCtrlPkg::motorCount; m = m + 1) begin : gMotor
        logic                                 speedPush;
        logic [motorCtrlPkg::wordWidth-1:0]   speedData;
        logic                                 voltPush;
        logic                                 ampPush;
        logic [motorCtrlPkg::sampleWidth-1:0] voltData;
        logic [motorCtrlPkg::sampleWidth-1:0] ampData;

        // speed msb is the valid strobe, stored cleared
        assign speedPush = speedIn[m][motorCtrlPkg::wordWidth-1];
        assign speedData = {1'b0, speedIn[m][motorCtrlPkg::wordWidth-2:0]};

        // top two bits strobe the two halves independently
        assign voltPush = sensorIn[m][motorCtrlPkg::sensorWidth-1];
        assign ampPush  = sensorIn[m][motorCtrlPkg::sensorWidth-2];
        assign voltData = sensorIn[m][2*motorCtrlPkg::sampleWidth-1:motorCtrlPkg::sampleWidth];
        assign ampData  = sensorIn[m][motorCtrlPkg::sampleWidth-1:0];

        sensorFifo #(
            .dataWidth (motorCtrlPkg::wordWidth),
            .depth     (motorCtrlPkg::fifoDepth)
        ) speedFifo (
            .clk      (clk),
            .reset_n  (reset_n),
            .clear    (clearAll),
            .push     (speedPush),
            .pushData (speedData),
            .pop      (popSpeed[m]),
            .head     (speedHead[m]),
            .notEmpty (speedNotEmpty[m])
        );

        sensorFifo #(
            .dataWidth (motorCtrlPkg::sampleWidth),
            .depth     (motorCtrlPkg::fifoDepth)
        ) voltFifo (
            .clk      (clk),
            .reset_n  (reset_n),
            .clear    (clearAll),
            .push     (voltPush),
            .pushData (voltData),
            .pop      (popVolt[m]),
            .head     (voltHead[m]),
            .notEmpty (voltNotEmpty[m])
        );

        sensorFifo #(
            .dataWidth (motorCtrlPkg::sampleWidth),
            .depth     (motorCtrlPkg::fifoDepth)
        ) ampFifo (
            .clk      (clk),
            .reset_n  (reset_n),
            .clear    (clearAll),
            .push     (ampPush),
            .pushData (ampData),
            .pop      (popAmp[m]),
            .head     (ampHead[m]),
            .notEmpty (ampNotEmpty[m])
        );
    end

    // ========================================
    // status word
    // ========================================
    always_comb begin
        fifoStatus = '0;
        for (int i = 0; i < motorCtrlPkg::motorCount; i++) begin
            fifoStatus[i] = speedNotEmpty[i];
            // sensor flags start at bit 8, voltage then current
            fifoStatus[8 + 2*i] = voltNotEmpty[i];
            fifoStatus[9 + 2*i] = ampNotEmpty[i];
        end
    end

endmodule

`default_nettype wire

// ==== logic/motorRegFile.sv ====
/*
 * motor register file
 * bus decode, control registers, registered read mux and fifo pops
 */
`timescale 1ns/1ps
`default_nettype none

module motorRegFile (
    input  wire                                   clk,
    input  wire                                   reset_n,
    input  wire  [motorCtrlPkg::addrWidth-1:0]    address,
    input  wire                                   read,
    input  wire                                   write,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    writedata,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    fbDirection,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    encoder [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::wordWidth-1:0]    fifoStatus,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    speedHead [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::sampleWidth-1:0]  voltHead [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::sampleWidth-1:0]  ampHead [motorCtrlPkg::motorCount],
    output logic [motorCtrlPkg::wordWidth-1:0]    readdata,
    output logic                                  waitrequest,
    output logic [motorCtrlPkg::wordWidth-1:0]    pwmDuty,
    output logic [motorCtrlPkg::wordWidth-1:0]    driverDir,
    output logic [motorCtrlPkg::wordWidth-1:0]    motorCtrl,
    output logic [motorCtrlPkg::motorCount-1:0]   popSpeed,
    output logic [motorCtrlPkg::motorCount-1:0]   popVolt,
    output logic [motorCtrlPkg::motorCount-1:0]   popAmp
);

    // motor block decode, index 0..3 and offset 0..4
    logic                               inMotor;
    logic [1:0]                         motorIdx;
    logic [2:0]                         motorOff;
    logic [motorCtrlPkg::wordWidth-1:0] readNext;
    motorCtrlPkg::adcSample_u           voltSample;
    motorCtrlPkg::adcSample_u           ampSample;

    // no back-pressure, every access completes in its cycle
    assign waitrequest = 1'b0;

    // ========================================
    // address decode
    // ========================================
    always_comb begin
        inMotor  = 1'b0;
        motorIdx = '0;
        motorOff = '0;
        for (int m = 0; m < motorCtrlPkg::motorCount; m++) begin
            if (address >= motorCtrlPkg::addrMotorBase + m * motorCtrlPkg::motorStride &&
                address < motorCtrlPkg::addrMotorBase + (m + 1) * motorCtrlPkg::motorStride) begin
                inMotor  = 1'b1;
                motorIdx = 2'(m);
                motorOff = 3'(address - (motorCtrlPkg::addrMotorBase +
                                         m * motorCtrlPkg::motorStride));
            end
        end
    end

    // pops fire with the read itself, fifo advances on the capture edge
    always_comb begin
        popSpeed = '0;
        popVolt  = '0;
        popAmp   = '0;
        if (read && inMotor) begin
            case (motorOff)
                motorCtrlPkg::offSpeed: popSpeed[motorIdx] = 1'b1;
                motorCtrlPkg::offVolt:  popVolt[motorIdx]  = 1'b1;
                motorCtrlPkg::offAmp:   popAmp[motorIdx]   = 1'b1;
                default: ;
            endcase
        end
    end

    // ========================================
    // read mux
    // ========================================
    assign voltSample.raw = voltHead[motorIdx];
    assign ampSample.raw  = ampHead[motorIdx];

    always_comb begin
        // anything unmapped reads the fixed pattern
        readNext = motorCtrlPkg::reservedPattern;
        case (address)
            motorCtrlPkg::addrPwmDuty:    readNext = pwmDuty;
            motorCtrlPkg::addrDriverDir:  readNext = driverDir;
            motorCtrlPkg::addrFbDir:      readNext = fbDirection;
            motorCtrlPkg::addrControl:    readNext = motorCtrl;
            motorCtrlPkg::addrFifoStatus: readNext = fifoStatus;
            default: begin
                if (inMotor) begin
                    case (motorOff)
                        motorCtrlPkg::offEncoder: readNext = encoder[motorIdx];
                        motorCtrlPkg::offSpeed:   readNext = speedHead[motorIdx];
                        // samples return only the adc field, zero-extended
                        motorCtrlPkg::offVolt: begin
                            readNext = {{(motorCtrlPkg::wordWidth - motorCtrlPkg::adcWidth){1'b0}},
                                        voltSample.field.adc};
                        end
                        motorCtrlPkg::offAmp: begin
                            readNext = {{(motorCtrlPkg::wordWidth - motorCtrlPkg::adcWidth){1'b0}},
                                        ampSample.field.adc};
                        end
                        default: ;
                    endcase
                end
            end
        endcase
    end

    // ========================================
    // registers
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            readdata  <= '0;
            pwmDuty   <= '0;
            driverDir <= '0;
            motorCtrl <= '0;
        end else begin
            // readdata holds between reads
            if (read) begin
                readdata <= readNext;
            end
            // read-only and reserved addresses fall through
            if (write) begin
                case (address)
                    motorCtrlPkg::addrPwmDuty:   pwmDuty   <= writedata;
                    motorCtrlPkg::addrDriverDir: driverDir <= writedata;
                    motorCtrlPkg::addrControl:   motorCtrl <= writedata;
                    default: ;
                endcase
            end
        end
    end

    // master side contract
    noReadWrite: assert property (@(posedge clk) disable iff (!reset_n) !(read && write))
        else $error("read and write asserted together");

endmodule

`default_nettype wire

// ==== logic/motorCtrlAvs.sv ====
/*
 * motor control avalon slave
 * register file for a four-motor drive board with feedback fifos
 */
`timescale 1ns/1ps
`default_nettype none

module motorCtrlAvs (
    input  wire                                   clk,
    input  wire                                   reset_n,

    // bus
    input  wire  [motorCtrlPkg::addrWidth-1:0]    address,
    input  wire                                   read,
    input  wire                                   write,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    writedata,
    output logic [motorCtrlPkg::wordWidth-1:0]    readdata,
    output logic                                  waitrequest,

    // feedback from the motor logic
    input  wire  [motorCtrlPkg::wordWidth-1:0]    fbDirection,
    input  wire  [motorCtrlPkg::wordWidth-1:0]    encoder [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::wordWidth-1:0]    speedIn [motorCtrlPkg::motorCount],
    input  wire  [motorCtrlPkg::sensorWidth-1:0]  sensorIn [motorCtrlPkg::motorCount],

    // control out to the motor logic
    output logic [motorCtrlPkg::wordWidth-1:0]    pwmDuty,
    output logic [motorCtrlPkg::wordWidth-1:0]    driverDir,
    output logic [motorCtrlPkg::wordWidth-1:0]    motorCtrl
);

    logic [motorCtrlPkg::wordWidth-1:0]   fifoStatus;
    logic [motorCtrlPkg::wordWidth-1:0]   speedHead [motorCtrlPkg::motorCount];
    logic [motorCtrlPkg::sampleWidth-1:0] voltHead [motorCtrlPkg::motorCount];
    logic [motorCtrlPkg::sampleWidth-1:0] ampHead [motorCtrlPkg::motorCount];
    logic [motorCtrlPkg::motorCount-1:0]  popSpeed;
    logic [motorCtrlPkg::motorCount-1:0]  popVolt;
    logic [motorCtrlPkg::motorCount-1:0]  popAmp;
    logic                                 clearAll;

    // fifo clear straight from the control register
    assign clearAll = motorCtrl[motorCtrlPkg::clearAllBit];

    motorRegFile regFile (
        .clk         (clk),
        .reset_n     (reset_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .fbDirection (fbDirection),
        .encoder     (encoder),
        .fifoStatus  (fifoStatus),
        .speedHead   (speedHead),
        .voltHead    (voltHead),
        .ampHead     (ampHead),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .pwmDuty     (pwmDuty),
        .driverDir   (driverDir),
        .motorCtrl   (motorCtrl),
        .popSpeed    (popSpeed),
        .popVolt     (popVolt),
        .popAmp      (popAmp)
    );

    feedbackBank fbBank (
        .clk        (clk),
        .reset_n    (reset_n),
        .clearAll   (clearAll),
        .speedIn    (speedIn),
        .sensorIn   (sensorIn),
        .popSpeed   (popSpeed),
        .popVolt    (popVolt),
        .popAmp     (popAmp),
        .speedHead  (speedHead),
        .voltHead   (voltHead),
        .ampHead    (ampHead),
        .fifoStatus (fifoStatus)
    );

endmodule

`default_nettype wire

// ==== tests/tbClock.sv ====
/*
 * testbench clock and reset
 * 4 ns clock, reset held low for the first 4 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release on a rising edge, like any other driven input
    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/tbMotorCtrlAvs.sv ====
/*
 * testbench for the motor control slave
 * random bus traffic and strobes checked against queue models
 */
`timescale 1ns/1ps
`default_nettype none

module tbMotorCtrlAvs;

    // six tests take under 3000 cycles, limit leaves wide margin
    localparam int cycleLimit = 20000;

    logic        clk;
    logic        reset_n;
    logic [4:0]  address;
    logic        read;
    logic        write;
    logic [31:0] writedata;
    logic [31:0] readdata;
    logic        waitrequest;
    logic [31:0] fbDirection;
    logic [31:0] encoder [4];
    logic [31:0] speedIn [4];
    logic [33:0] sensorIn [4];
    logic [31:0] pwmDuty;
    logic [31:0] driverDir;
    logic [31:0] motorCtrl;

    // model state
    logic [31:0] modelPwm;
    logic [31:0] modelDir;
    logic [31:0] modelCtrl;
    logic [31:0] speedQ [4][$];
    logic [15:0] voltQ [4][$];
    logic [15:0] ampQ [4][$];

    logic [31:0] rngState = 32'h2bbaf3b7;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          errorsAtStart = 0;

    tbClock clockGen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    motorCtrlAvs u_dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .fbDirection (fbDirection),
        .encoder     (encoder),
        .speedIn     (speedIn),
        .sensorIn    (sensorIn),
        .pwmDuty     (pwmDuty),
        .driverDir   (driverDir),
        .motorCtrl   (motorCtrl)
    );

    // ========================================
    // helpers
    // ========================================
    // xorshift32
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic [4:0] motorAddr(input int m, input int off);
        return 5'(motorCtrlPkg::addrMotorBase + m * motorCtrlPkg::motorStride + off);
    endfunction

    // bus returns only the adc field of a sample
    function automatic logic [31:0] adcWord(input logic [15:0] raw);
        motorCtrlPkg::adcSample_u s;
        s.raw = raw;
        return {20'b0, s.field.adc};
    endfunction

    // expected status word from the model occupancy
    function automatic logic [31:0] modelStatus();
        logic [31:0] s;
        s = '0;
        for (int m = 0; m < 4; m++) begin
            s[m]         = (speedQ[m].size() != 0);
            s[8 + 2 * m] = (voltQ[m].size() != 0);
            s[9 + 2 * m] = (ampQ[m].size() != 0);
        end
        return s;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic finishTest(input string name);
        $display("test %s done, %0d errors", name, errors - errorsAtStart);
        errorsAtStart = errors;
    endtask

    // ========================================
    // bus and strobe drivers
    // ========================================
    task automatic busWrite(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        address   <= a;
        writedata <= d;
        write     <= 1'b1;
        @(posedge clk);
        write     <= 1'b0;
        if (a == motorCtrlPkg::addrPwmDuty) modelPwm = d;
        if (a == motorCtrlPkg::addrDriverDir) modelDir = d;
        if (a == motorCtrlPkg::addrControl) modelCtrl = d;
        // clear bit empties every fifo
        if (modelCtrl[motorCtrlPkg::clearAllBit]) begin
            for (int m = 0; m < 4; m++) begin
                speedQ[m].delete();
                voltQ[m].delete();
                ampQ[m].delete();
            end
        end
        @(negedge clk);
    endtask

    // readdata settles one edge after the read cycle
    task automatic busRead(input logic [4:0] a, output logic [31:0] data);
        @(posedge clk);
        address <= a;
        read    <= 1'b1;
        @(posedge clk);
        read    <= 1'b0;
        @(negedge clk);
        data = readdata;
    endtask

    task automatic readCheck(input logic [4:0] a, input logic [31:0] expected,
                             input string what);
        logic [31:0] got;
        busRead(a, got);
        checkValue(got, expected, what);
    endtask

    task automatic checkExports();
        checkValue(pwmDuty, modelPwm, "pwmDuty output");
        checkValue(driverDir, modelDir, "driverDir output");
        checkValue(motorCtrl, modelCtrl, "motorCtrl output");
    endtask

    // one-cycle strobe, stored without its valid bit
    task automatic strobeSpeed(input int m, input logic [31:0] value);
        @(posedge clk);
        speedIn[m] <= value;
        if (!modelCtrl[motorCtrlPkg::clearAllBit] && speedQ[m].size() < 8) begin
            speedQ[m].push_back({1'b0, value[30:0]});
        end
        @(posedge clk);
        speedIn[m] <= '0;
    endtask

    task automatic strobeSensor(input int m, input logic voltStb, input logic ampStb,
                                input logic [31:0] samples);
        logic clearing;
        clearing = modelCtrl[motorCtrlPkg::clearAllBit];
        @(posedge clk);
        sensorIn[m] <= {voltStb, ampStb, samples};
        // full fifos drop the new sample
        if (voltStb && !clearing && voltQ[m].size() < 8) voltQ[m].push_back(samples[31:16]);
        if (ampStb && !clearing && ampQ[m].size() < 8) ampQ[m].push_back(samples[15:0]);
        @(posedge clk);
        sensorIn[m] <= '0;
    endtask

    // ========================================
    // tests
    // ========================================
    task automatic testRegisters();
        logic [31:0] r;
        logic [31:0] d;
        logic [4:0]  a;
        for (int i = 0; i < 30; i++) begin
            r = nextRandom();
            d = nextRandom();
            if (r % 3 == 0) a = 5'(motorCtrlPkg::addrPwmDuty);
            else if (r % 3 == 1) a = 5'(motorCtrlPkg::addrDriverDir);
            else a = 5'(motorCtrlPkg::addrControl);
            // keep the fifos out of clear
            if (a == motorCtrlPkg::addrControl) d[motorCtrlPkg::clearAllBit] = 1'b0;
            busWrite(a, d);
            checkExports();
            readCheck(a, d, "register read back");
        end
        // writes to read-only and reserved addresses
        for (int i = 0; i < 12; i++) begin
            a = 5'(nextRandom() % 30 + 2);
            if (a == motorCtrlPkg::addrControl) a = 5'(motorCtrlPkg::addrFbDir);
            busWrite(a, nextRandom());
            checkExports();
        end
        readCheck(5'(motorCtrlPkg::addrPwmDuty), modelPwm, "pwmDuty after ignored writes");
        readCheck(5'(motorCtrlPkg::addrDriverDir), modelDir, "driverDir after ignored writes");
        readCheck(5'(motorCtrlPkg::addrControl), modelCtrl, "control after ignored writes");
    endtask

    task automatic testDirectInputs();
        logic [31:0] fbVal;
        logic [31:0] encVal [4];
        for (int i = 0; i < 4; i++) begin
            fbVal = nextRandom();
            @(posedge clk);
            fbDirection <= fbVal;
            for (int m = 0; m < 4; m++) begin
                encVal[m] = nextRandom();
                encoder[m] <= encVal[m];
            end
            readCheck(5'(motorCtrlPkg::addrFbDir), fbVal, "feedback direction");
            for (int m = 0; m < 4; m++) begin
                readCheck(motorAddr(m, motorCtrlPkg::offEncoder), encVal[m], "encoder");
            end
        end
        // offset 4 of each motor, the old registers 5 and 6, and the top of the map
        for (int m = 0; m < 4; m++) begin
            readCheck(motorAddr(m, 4), motorCtrlPkg::reservedPattern, "reserved offset");
        end
        readCheck(5'd5, motorCtrlPkg::reservedPattern, "reserved address 5");
        readCheck(5'd6, motorCtrlPkg::reservedPattern, "reserved address 6");
        for (int a = 27; a < 32; a++) begin
            readCheck(5'(a), motorCtrlPkg::reservedPattern, "unmapped address");
        end
    endtask

    task automatic testSpeedFifos();
        logic [31:0] r;
        logic [31:0] got;
        logic [31:0] expected;
        int          m;
        for (int i = 0; i < 160; i++) begin
            r = nextRandom();
            m = int'(r[1:0]);
            if (r[2]) begin
                strobeSpeed(m, nextRandom() | 32'h8000_0000);
            end else begin
                busRead(motorAddr(m, motorCtrlPkg::offSpeed), got);
                // empty read returns nothing defined
                if (speedQ[m].size() > 0) begin
                    expected = speedQ[m].pop_front();
                    checkValue(got, expected, "speed fifo entry");
                end
            end
            busRead(5'(motorCtrlPkg::addrFifoStatus), got);
            checkValue(got, modelStatus(), "speed status");
        end
    endtask

    task automatic testSensorFifos();
        logic [31:0] r;
        logic [31:0] got;
        logic [15:0] sample;
        int          m;
        for (int i = 0; i < 200; i++) begin
            r = nextRandom();
            m = int'(r[1:0]);
            // mostly pushes, so the fifos overflow
            if (r[3:2] != 2'b00) begin
                strobeSensor(m, r[4], r[5], nextRandom());
            end else if (r[4]) begin
                busRead(motorAddr(m, motorCtrlPkg::offVolt), got);
                if (voltQ[m].size() > 0) begin
                    sample = voltQ[m].pop_front();
                    checkValue(got, adcWord(sample), "voltage fifo entry");
                end
            end else begin
                busRead(motorAddr(m, motorCtrlPkg::offAmp), got);
                if (ampQ[m].size() > 0) begin
                    sample = ampQ[m].pop_front();
                    checkValue(got, adcWord(sample), "current fifo entry");
                end
            end
            busRead(5'(motorCtrlPkg::addrFifoStatus), got);
            checkValue(got, modelStatus(), "sensor status");
        end
    endtask

    task automatic testClear();
        for (int m = 0; m < 4; m++) begin
            for (int k = 0; k < motorCtrlPkg::fifoDepth; k++) begin
                strobeSpeed(m, nextRandom() | 32'h8000_0000);
                strobeSensor(m, 1'b1, 1'b1, nextRandom());
            end
        end
        readCheck(5'(motorCtrlPkg::addrFifoStatus), modelStatus(), "status when filled");
        busWrite(5'(motorCtrlPkg::addrControl), 32'h8000_0000);
        checkExports();
        // strobes while clearing are not stored
        for (int m = 0; m < 4; m++) begin
            strobeSpeed(m, nextRandom() | 32'h8000_0000);
            strobeSensor(m, 1'b1, 1'b1, nextRandom());
        end
        repeat (3) @(posedge clk);
        busWrite(5'(motorCtrlPkg::addrControl), 32'h0);
        checkExports();
        readCheck(5'(motorCtrlPkg::addrFifoStatus), 32'h0, "status after clear");
    endtask

    // ========================================
    // run
    // ========================================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: the tests were still running after %0d cycles", cycleLimit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        address     <= '0;
        read        <= 1'b0;
        write       <= 1'b0;
        writedata   <= '0;
        fbDirection <= '0;
        for (int m = 0; m < 4; m++) begin
            encoder[m]  <= '0;
            speedIn[m]  <= '0;
            sensorIn[m] <= '0;
        end
        modelPwm  = '0;
        modelDir  = '0;
        modelCtrl = '0;
        @(posedge reset_n);
        @(negedge clk);

        checkExports();
        checkValue({31'b0, waitrequest}, 32'h0, "waitrequest");
        readCheck(5'(motorCtrlPkg::addrFifoStatus), 32'h0, "status after reset");
        finishTest("reset");
        testRegisters();
        finishTest("registers");
        testDirectInputs();
        finishTest("direct inputs");
        testSpeedFifos();
        finishTest("speed fifos");
        testSensorFifos();
        finishTest("sensor fifos");
        testClear();
        finishTest("fifo clear");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/motorCtrlPkg.sv
logic/sensorFifo.sv
logic/feedbackBank.sv
logic/motorRegFile.sv
logic/motorCtrlAvs.sv
tests/tbClock.sv
tests/tbMotorCtrlAvs.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# the verdict comes from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tbMotorCtrlAvs -o tbSim > build.log 2>&1 &&
./obj_dir/tbSim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass line found in sim.log"; exit 1; }
echo "simulation passed"
